/* hw/des_defs.svh */
`ifndef DES_DEFS_SVH
`define DES_DEFS_SVH

// Datapath widths

// Full cipher block
`define DES_BLOCK_W 64

// One Feistel half
`define DES_HALF_W 32

// One key-schedule half (C or D)
`define DES_CD_W 28

// Round key after PC2
`define DES_RKEY_W 48

// Feistel rounds per block
`define DES_ROUNDS 16

`endif

/* hw/des_pkg.sv */
`default_nettype none

`include "des_defs.svh"

package des_pkg;

    typedef logic [`DES_BLOCK_W-1:0] block_t;
    typedef logic [`DES_HALF_W-1:0]  half_t;
    typedef logic [`DES_RKEY_W-1:0]  round_key_t;

    typedef struct packed {
        logic [`DES_CD_W-1:0] c;
        logic [`DES_CD_W-1:0] d;
    } cd_t;

    typedef struct packed {
        logic   valid;
        logic   decrypt;
        block_t data;
    } des_req_t;

    typedef struct packed {
        logic   valid;
        block_t data;
    } des_rsp_t;

    typedef struct packed {
        logic   valid;
        block_t key;
    } key_load_t;

    // Rounds 1, 2, 9 and 16 rotate by one, bit 0 is round 1
    localparam logic [`DES_ROUNDS-1:0] shift_one_mask = 16'h8103;

    // ------------------------------------------------------------
    // S-boxes, entry index is {row, column}
    // ------------------------------------------------------------
    localparam logic [3:0] sbox_table [8][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

    // ------------------------------------------------------------
    // Bit tables, entry i gives the source bit of output bit i+1
    // ------------------------------------------------------------
    localparam int unsigned ip_tab [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

    localparam int unsigned fp_tab [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25};

    localparam int unsigned e_tab [48] = '{
        32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};

    localparam int unsigned p_tab [32] = '{
        16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};

    // Parity bits 8, 16 .. 64 never appear here
    localparam int unsigned pc1_tab [56] = '{
        57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
        10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
        14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};

    localparam int unsigned pc2_tab [48] = '{
        14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
        26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

    // ------------------------------------------------------------
    // Permutations, bit 1 of each table is the MSB
    // ------------------------------------------------------------
    function automatic block_t ip_perm(block_t d);
        block_t r;
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            r[`DES_BLOCK_W-1-i] = d[`DES_BLOCK_W-ip_tab[i]];
        end
        return r;
    endfunction

    function automatic block_t fp_perm(block_t d);
        block_t r;
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            r[`DES_BLOCK_W-1-i] = d[`DES_BLOCK_W-fp_tab[i]];
        end
        return r;
    endfunction

    function automatic round_key_t e_expand(half_t h);
        round_key_t r;
        for (int i = 0; i < `DES_RKEY_W; i++) begin
            r[`DES_RKEY_W-1-i] = h[`DES_HALF_W-e_tab[i]];
        end
        return r;
    endfunction

    function automatic half_t p_perm(half_t h);
        half_t r;
        for (int i = 0; i < `DES_HALF_W; i++) begin
            r[`DES_HALF_W-1-i] = h[`DES_HALF_W-p_tab[i]];
        end
        return r;
    endfunction

    function automatic cd_t pc1_perm(block_t k);
        logic [2*`DES_CD_W-1:0] r;
        for (int i = 0; i < 2*`DES_CD_W; i++) begin
            r[2*`DES_CD_W-1-i] = k[`DES_BLOCK_W-pc1_tab[i]];
        end
        return r;
    endfunction

    function automatic round_key_t pc2_perm(cd_t cd);
        logic [2*`DES_CD_W-1:0] v;
        round_key_t r;
        v = cd;
        for (int i = 0; i < `DES_RKEY_W; i++) begin
            r[`DES_RKEY_W-1-i] = v[2*`DES_CD_W-pc2_tab[i]];
        end
        return r;
    endfunction

endpackage

`default_nettype wire

/* hw/des_key_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module des_key_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  des_pkg::key_load_t    key_load,
    input  logic                  busy,
    output des_pkg::cd_t          key_cd
);
    import des_pkg::*;

    logic load_ok;

    // Key is frozen while a block is in flight
    assign load_ok = key_load.valid && !busy;

    // Only the 56 PC1 bits are kept, parity is dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_cd <= '0;
        end else if (load_ok) begin
            key_cd <= pc1_perm(key_load.key);
        end
    end

endmodule

`default_nettype wire

/* hw/des_key_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

`include "des_defs.svh"

module des_key_schedule (
    input  logic                  clk,
    input  logic                  rst_n,
    input  des_pkg::cd_t          key_cd,
    input  logic                  round_load,
    input  logic                  round_step,
    input  logic                  decrypt_mode,
    output des_pkg::round_key_t   round_key
);
    import des_pkg::*;

    localparam int unsigned idx_w = $clog2(`DES_ROUNDS);

    cd_t              cd_q;
    logic [idx_w-1:0] idx;
    logic [idx_w-1:0] idx_next;
    logic             one_bit;

    // Rotate one 28-bit half by one or two places
    function automatic logic [`DES_CD_W-1:0] rot_half(logic [`DES_CD_W-1:0] h,
                                                      logic right, logic one);
        logic [2*`DES_CD_W-1:0] dbl;
        int unsigned amt;
        dbl = {h, h};
        amt = one ? 1 : 2;
        if (right) begin
            return dbl[amt +: `DES_CD_W];
        end
        return dbl[`DES_CD_W-amt +: `DES_CD_W];
    endfunction

    assign idx_next = idx + idx_w'(1);

    // Shift for the next round, decryption reads the mask backwards
    assign one_bit = decrypt_mode ? shift_one_mask[~idx] : shift_one_mask[idx_next];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (round_load) begin
            idx <= '0;
        end else if (round_step) begin
            idx <= idx_next;
        end
    end

    // ------------------------------------------------------------
    // C/D registers
    // ------------------------------------------------------------
    // Decrypt starts from C0D0, which is also C16D16
    always_ff @(posedge clk) begin
        if (round_load) begin
            if (decrypt_mode) begin
                cd_q <= key_cd;
            end else begin
                cd_q.c <= rot_half(key_cd.c, 1'b0, shift_one_mask[0]);
                cd_q.d <= rot_half(key_cd.d, 1'b0, shift_one_mask[0]);
            end
        end else if (round_step) begin
            cd_q.c <= rot_half(cd_q.c, decrypt_mode, one_bit);
            cd_q.d <= rot_half(cd_q.d, decrypt_mode, one_bit);
        end
    end

    assign round_key = pc2_perm(cd_q);

endmodule

`default_nettype wire

/* hw/des_feistel_f.sv */
`timescale 1ns/1ps
`default_nettype none

`include "des_defs.svh"

module des_feistel_f (
    input  des_pkg::half_t        r_half,
    input  des_pkg::round_key_t   round_key,
    output des_pkg::half_t        f_out
);
    import des_pkg::*;

    localparam int unsigned n_sbox = `DES_RKEY_W / 6;

    round_key_t mixed;
    half_t      sub;

    // Expansion and key mix
    assign mixed = e_expand(r_half) ^ round_key;

    // Six bits in, four out per box, S1 takes the top bits
    always_comb begin
        logic [5:0] six;
        sub = '0;
        for (int b = 0; b < n_sbox; b++) begin
            six = mixed[`DES_RKEY_W-1-6*b -: 6];
            // Outer bits pick the row, inner four the column
            sub[`DES_HALF_W-1-4*b -: 4] = sbox_table[b][{six[5], six[0], six[4:1]}];
        end
    end

    assign f_out = p_perm(sub);

endmodule

`default_nettype wire

/* hw/des_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "des_defs.svh"

module des_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  des_pkg::des_req_t  req,
    input  des_pkg::half_t     f_out,
    output des_pkg::half_t     r_half,
    output logic               round_load,
    output logic               round_step,
    output logic               decrypt_mode,
    output logic               busy,
    output des_pkg::des_rsp_t  rsp
);
    import des_pkg::*;

    // Count 0 is idle, 1..16 are rounds, 17 is the output slot
    localparam int unsigned      cnt_w    = $clog2(`DES_ROUNDS + 2);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`DES_ROUNDS + 1);

    logic [cnt_w-1:0] cnt;
    logic             decrypt_q;
    logic             accept;
    logic             out_slot;
    half_t            l_q;
    half_t            r_q;

    assign busy     = (cnt != '0);
    assign accept   = req.valid && !busy;
    assign out_slot = (cnt == cnt_last);

    // ------------------------------------------------------------
    // Key schedule control
    // ------------------------------------------------------------
    assign round_load = accept;
    assign round_step = busy && !out_slot;

    // Request bit on the load edge, stored bit during the run
    assign decrypt_mode = busy ? decrypt_q : req.decrypt;

    assign r_half = r_q;

    // ------------------------------------------------------------
    // Round counter
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            decrypt_q <= 1'b0;
        end else if (accept) begin
            cnt       <= cnt_w'(1);
            decrypt_q <= req.decrypt;
        end else if (out_slot) begin
            cnt <= '0;
        end else if (busy) begin
            cnt <= cnt + cnt_w'(1);
        end
    end

    // ------------------------------------------------------------
    // L/R halves
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            {l_q, r_q} <= ip_perm(req.data);
        end else if (round_step) begin
            l_q <= r_q;
            r_q <= l_q ^ f_out;
        end
    end

    // Result is FP of R16 L16, swapped after the last round
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp.valid <= out_slot;
            if (out_slot) begin
                rsp.data <= fp_perm({r_q, l_q});
            end
        end
    end

endmodule

`default_nettype wire

/* hw/des_top.sv */
`timescale 1ns/1ps
`default_nettype none

module des_top (
    input  logic                clk,
    input  logic                rst_n,
    input  des_pkg::key_load_t  key_load,
    input  des_pkg::des_req_t   req,
    output des_pkg::des_rsp_t   rsp,
    output logic                busy
);
    import des_pkg::*;

    cd_t        key_cd;
    round_key_t round_key;
    half_t      r_half;
    half_t      f_out;
    logic       round_load;
    logic       round_step;
    logic       decrypt_mode;

    // Key store, frozen while busy
    des_key_regs u_key_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_load (key_load),
        .busy     (busy),
        .key_cd   (key_cd)
    );

    des_key_schedule u_key_schedule (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_cd       (key_cd),
        .round_load   (round_load),
        .round_step   (round_step),
        .decrypt_mode (decrypt_mode),
        .round_key    (round_key)
    );

    des_feistel_f u_feistel_f (
        .r_half    (r_half),
        .round_key (round_key),
        .f_out     (f_out)
    );

    // Round sequencing and request/response
    des_engine u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .f_out        (f_out),
        .r_half       (r_half),
        .round_load   (round_load),
        .round_step   (round_step),
        .decrypt_mode (decrypt_mode),
        .busy         (busy),
        .rsp          (rsp)
    );

endmodule

`default_nettype wire

/* sim/des_tb_vectors.svh */
`ifndef DES_TB_VECTORS_SVH
`define DES_TB_VECTORS_SVH

// Known-answer vectors
// Columns: kat_key is the 64-bit key with parity, kat_pt the plaintext, kat_ct the ciphertext

localparam int n_kat = 5;

localparam logic [63:0] kat_key [n_kat] = '{
    64'h133457799BBCDFF1,
    64'h0E329232EA6D0D73,
    64'h0000000000000000,
    64'hFFFFFFFFFFFFFFFF,
    64'h0123456789ABCDEF};

localparam logic [63:0] kat_pt [n_kat] = '{
    64'h0123456789ABCDEF,
    64'h8787878787878787,
    64'h0000000000000000,
    64'hFFFFFFFFFFFFFFFF,
    64'h4E6F772069732074};

localparam logic [63:0] kat_ct [n_kat] = '{
    64'h85E813540F0AB405,
    64'h0000000000000000,
    64'h8CA64DE9C1B123A7,
    64'h7359B2163E4EDC58,
    64'h3FA40E8A984D4815};

`endif

/* sim/des_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "des_defs.svh"

module des_tb;
    import des_pkg::*;

    `include "des_tb_vectors.svh"

    localparam int cycle_ns    = 4;
    localparam int reset_cyc   = 16;
    localparam int n_trips     = 40;
    localparam int last_busy   = `DES_ROUNDS + 1;
    localparam int rsp_age     = `DES_ROUNDS + 2;
    localparam int rsp_limit   = 40;
    localparam int n_requests  = 2 * n_kat + 2 * n_trips + 3;
    localparam int watchdog_ns = n_requests * 20 * cycle_ns + reset_cyc * cycle_ns + 2000;

    logic      clk = 1'b0;
    logic      rst_n;
    key_load_t key_load;
    des_req_t  req;
    des_rsp_t  rsp;
    logic      busy;

    int n_checks   = 0;
    int n_mismatch = 0;
    int n_timeouts = 0;

    always #2 clk = ~clk;

    des_top u_des_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_load (key_load),
        .req      (req),
        .rsp      (rsp),
        .busy     (busy)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        n_mismatch++;
        $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        n_checks++;
        assert (act_val === exp_val)
            else report_mismatch(name, exp_val, act_val);
    endtask

    // Key is sampled on the edge where this task returns
    task automatic load_key(input block_t k);
        @(posedge clk);
        key_load <= '{valid: 1'b1, key: k};
        @(posedge clk);
        key_load.valid <= 1'b0;
    endtask

    // Returns on the edge that accepts the request
    task automatic send_req(input logic dec, input block_t d);
        @(posedge clk);
        req <= '{valid: 1'b1, decrypt: dec, data: d};
        @(posedge clk);
        req.valid <= 1'b0;
    endtask

    task automatic wait_rsp(output block_t d);
        int n;
        n = 0;
        d = '0;
        do begin
            @(posedge clk);
            n++;
        end while (!rsp.valid && n < rsp_limit);
        if (rsp.valid) begin
            d = rsp.data;
        end else begin
            n_timeouts++;
            $display("ERROR at %0t: no response within %0d cycles", $time, rsp_limit);
        end
    endtask

    // ------------------------------------------------------------
    // Latency and busy monitor
    // ------------------------------------------------------------
    // age counts edges since the accepting edge and is 0 when idle
    int   age = 0;
    logic exp_busy;
    logic exp_valid;

    always @(posedge clk) begin
        if (rst_n) begin
            exp_busy  = (age >= 1) && (age <= last_busy);
            exp_valid = (age == rsp_age);
            assert (busy === exp_busy)
                else report_mismatch("busy", 64'(exp_busy), 64'(busy));
            assert (rsp.valid === exp_valid)
                else report_mismatch("rsp.valid", 64'(exp_valid), 64'(rsp.valid));
            // Requests seen while busy are dropped
            if (req.valid && !exp_busy) begin
                age = 1;
            end else if (age != 0 && age < rsp_age) begin
                age = age + 1;
            end else begin
                age = 0;
            end
        end else begin
            age = 0;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("ERROR: watchdog expired at %0t, the run did not finish", $time);
        $display("Simulation FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        block_t res;
        block_t key;
        block_t blk;
        block_t ct;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'ha6addf88));
        rst_n    = 1'b0;
        req      = '0;
        key_load = '0;
        repeat (reset_cyc) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("busy", 64'(1'b0), 64'(busy));
        check_value("rsp.valid", 64'(1'b0), 64'(rsp.valid));

        // Known answers in both directions
        for (int i = 0; i < n_kat; i++) begin
            load_key(kat_key[i]);
            send_req(1'b0, kat_pt[i]);
            wait_rsp(res);
            check_value("rsp.data (encrypt)", kat_ct[i], res);
            send_req(1'b1, kat_ct[i]);
            wait_rsp(res);
            check_value("rsp.data (decrypt)", kat_pt[i], res);
        end

        // Random round trips
        for (int i = 0; i < n_trips; i++) begin
            key = {$urandom, $urandom};
            blk = {$urandom, $urandom};
            load_key(key);
            send_req(1'b0, blk);
            wait_rsp(ct);
            send_req(1'b1, ct);
            wait_rsp(res);
            check_value("rsp.data (round trip)", blk, res);
        end

        // Request and key load in mid-run must both be dropped
        load_key(kat_key[0]);
        send_req(1'b0, kat_pt[0]);
        repeat (5) @(posedge clk);
        req      <= '{valid: 1'b1, decrypt: 1'b1, data: kat_ct[1]};
        key_load <= '{valid: 1'b1, key: kat_key[1]};
        @(posedge clk);
        req.valid      <= 1'b0;
        key_load.valid <= 1'b0;
        wait_rsp(res);
        check_value("rsp.data (busy run)", kat_ct[0], res);
        repeat (25) @(posedge clk);
        send_req(1'b0, kat_pt[0]);
        wait_rsp(res);
        check_value("rsp.data (after busy load)", kat_ct[0], res);
        repeat (4) @(posedge clk);

        $display("Data checks: %0d, mismatches: %0d, timeouts: %0d",
                 n_checks, n_mismatch, n_timeouts);
        if (n_mismatch == 0 && n_timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
+incdir+sim
hw/des_pkg.sv
hw/des_key_regs.sv
hw/des_key_schedule.sv
hw/des_feistel_f.sv
hw/des_engine.sv
hw/des_top.sv
sim/des_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DES testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module des_tb -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vdes_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation run returned status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
